// File: Bender.yml
package:
  name: predictor

sources:
  - rtl/bp_isa_pkg.sv
  - rtl/bp_pipe_pkg.sv
  - rtl/kind_table.sv
  - rtl/bht.sv
  - rtl/ghr.sv
  - rtl/dir_predictor.sv
  - rtl/target_predictor.sv
  - rtl/predictor.sv
  - target: simulation
    files:
      - verif/predictor_checker.sv
      - verif/predictor_properties.sv
      - verif/tb_predictor.sv

// File: build.f
rtl/bp_isa_pkg.sv
rtl/bp_pipe_pkg.sv
rtl/kind_table.sv
rtl/bht.sv
rtl/ghr.sv
rtl/dir_predictor.sv
rtl/target_predictor.sv
rtl/predictor.sv
verif/predictor_checker.sv
verif/predictor_properties.sv
verif/tb_predictor.sv

// File: rtl/bht.sv
module bht #(
    parameter int k_width = 6,
    parameter int h_width = 8
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [k_width-1:0] rd_idx,
    output logic [h_width-1:0] bh,
    input  logic               update_en,
    input  logic [k_width-1:0] wr_idx,
    input  logic [h_width-1:0] wr_bh,
    input  logic               taken
);
    localparam int entries = 1 << k_width;

    logic [h_width-1:0] bh_mem [entries];

    assign bh = bh_mem[rd_idx];

    // history starts empty for every branch
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < entries; i++) begin
                bh_mem[i] <= '0;
            end
        end else if (update_en) begin
            // history seen at fetch plus the real outcome
            bh_mem[wr_idx] <= {wr_bh[h_width-2:0], taken};
        end
    end

endmodule

// File: rtl/bp_isa_pkg.sv
package bp_isa_pkg;

    localparam int addr_w = 30;  // word address

    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        jump          = 3'd2,
        call          = 3'd3,
        ret           = 3'd4,
        indirect_jump = 3'd5,
        other_jump    = 3'd6
    } branch_kind_e;

    // xor-fold pc into the low width bits, upper bits stay zero
    function automatic logic [15:0] fold_hash(input logic [addr_w-1:0] pc,
                                              input int unsigned width);
        logic [15:0] res;
        res = '0;
        for (int i = 0; i < addr_w; i++) begin
            res[i % width] = res[i % width] ^ pc[i];
        end
        return res;
    endfunction

    function automatic logic [15:0] mix_hash(input logic [15:0] pc_fold,
                                             input logic [15:0] hist,
                                             input int unsigned width);
        logic [15:0] mask;
        mask = (16'(1) << width) - 16'(1);
        return (fold_hash(addr_w'(pc_fold), width) ^ hist) & mask;
    endfunction

    // 2-bit saturating step
    function automatic logic [1:0] cnt_step(input logic [1:0] cnt, input logic up);
        if (up) begin
            return (cnt == 2'b11) ? cnt : cnt + 2'd1;
        end
        return (cnt == 2'b00) ? cnt : cnt - 2'd1;
    endfunction

endpackage

// File: rtl/bp_pipe_pkg.sv
package bp_pipe_pkg;

    typedef struct packed {
        logic npc;
        logic kind;
        logic taken;
    } mis_t;

    typedef struct packed {
        logic btb_ras;  // 1 stack, 0 btb
        logic loc_glb;  // 1 global, 0 local
    } choice_t;

    // resolved branch from execute
    typedef struct packed {
        logic [bp_isa_pkg::addr_w-1:0] pc;
        logic [bp_isa_pkg::addr_w-1:0] npc;
        logic [bp_isa_pkg::addr_w-1:0] ret_pc;
        bp_isa_pkg::branch_kind_e      kind;
        logic                          taken;
        logic [15:0]                   bh;
        choice_t                       choice_real;
        logic [1:0]                    choice_cnt_glb;
        logic [1:0]                    choice_cnt_ras;
        mis_t                          mis;
    } upd_t;

    typedef struct packed {
        logic [bp_isa_pkg::addr_w-1:0] npc;
        bp_isa_pkg::branch_kind_e      kind;
        logic                          taken;
        logic [15:0]                   bh;
        choice_t                       choice;
        logic [1:0]                    choice_cnt_glb;
        logic [1:0]                    choice_cnt_ras;
    } pred_t;

endpackage

// File: rtl/dir_predictor.sv
module dir_predictor #(
    parameter int k_width = 6,
    parameter int h_width = 8
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [k_width-1:0] pc_idx,
    input  logic [h_width-1:0] gh,
    input  logic [h_width-1:0] bh,
    input  bp_pipe_pkg::upd_t  upd,
    input  logic               update_en,
    input  logic [h_width-1:0] gh_commit,
    output logic               taken,
    output logic               choice_glb,
    output logic [1:0]         choice_cnt
);
    localparam int entries = 1 << h_width;
    localparam int cho_entries = 1 << k_width;

    logic [1:0]         glb_cnt [entries];
    logic [1:0]         loc_cnt [entries];
    logic [1:0]         cho_cnt [cho_entries];
    logic [15:0]        g_hash, l_hash;
    logic [15:0]        upd_fold, ug_hash, ul_hash;
    logic [h_width-1:0] g_idx, l_idx, ug_idx, ul_idx;
    logic [k_width-1:0] u_idx;
    logic               train;

    // fetch side
    assign g_hash = bp_isa_pkg::mix_hash(16'(pc_idx), 16'(gh), h_width);
    assign l_hash = bp_isa_pkg::mix_hash(16'(pc_idx), 16'(bh), h_width);
    assign g_idx  = g_hash[h_width-1:0];
    assign l_idx  = l_hash[h_width-1:0];

    assign choice_cnt = cho_cnt[pc_idx];
    assign choice_glb = choice_cnt[1];
    assign taken      = choice_glb ? glb_cnt[g_idx][1] : loc_cnt[l_idx][1];

    // update side, same hashes on the execute copy
    assign upd_fold = bp_isa_pkg::fold_hash(upd.pc, k_width);
    assign ug_hash  = bp_isa_pkg::mix_hash(upd_fold, 16'(gh_commit), h_width);
    assign ul_hash  = bp_isa_pkg::mix_hash(upd_fold, upd.bh, h_width);
    assign ug_idx   = ug_hash[h_width-1:0];
    assign ul_idx   = ul_hash[h_width-1:0];
    assign u_idx    = upd_fold[k_width-1:0];

    assign train = update_en && (upd.kind == bp_isa_pkg::direct_jump ||
                                 upd.kind == bp_isa_pkg::other_jump);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < entries; i++) begin
                glb_cnt[i] <= 2'b01;
                loc_cnt[i] <= 2'b01;
            end
            for (int j = 0; j < cho_entries; j++) begin
                cho_cnt[j] <= 2'b01;
            end
        end else if (train) begin
            glb_cnt[ug_idx] <= bp_isa_pkg::cnt_step(glb_cnt[ug_idx], upd.taken);
            loc_cnt[ul_idx] <= bp_isa_pkg::cnt_step(loc_cnt[ul_idx], upd.taken);
            // chooser steps from the value seen at fetch
            cho_cnt[u_idx]  <= bp_isa_pkg::cnt_step(upd.choice_cnt_glb,
                                                    upd.choice_real.loc_glb);
        end
    end

endmodule

// File: rtl/ghr.sv
module ghr #(
    parameter int h_width = 8
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               pred_jump,
    input  logic               pred_taken,
    input  logic               upd_jump,
    input  logic               upd_taken,
    input  logic               mis_taken,
    input  logic               update_en,
    output logic [h_width-1:0] gh,
    output logic [h_width-1:0] gh_commit
);

    // speculative copy, follows the predictions
    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh <= '0;
        end else if (update_en && mis_taken) begin
            gh <= {gh_commit[h_width-2:0], upd_taken};  // restore with real outcome
        end else if (!stall && pred_jump) begin
            gh <= {gh[h_width-2:0], pred_taken};
        end
    end

    // committed copy, follows execute
    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh_commit <= '0;
        end else if (update_en && upd_jump) begin
            gh_commit <= {gh_commit[h_width-2:0], upd_taken};
        end
    end

endmodule

// File: rtl/kind_table.sv
module kind_table #(
    parameter int k_width = 6
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [k_width-1:0]       rd_idx,
    output bp_isa_pkg::branch_kind_e kind,
    input  logic                     update_en,
    input  logic [k_width-1:0]       wr_idx,
    input  bp_isa_pkg::branch_kind_e wr_kind
);
    localparam int entries = 1 << k_width;

    bp_isa_pkg::branch_kind_e kind_mem [entries];
    logic [entries-1:0]       valid;

    // empty slots look like plain instructions
    assign kind = valid[rd_idx] ? kind_mem[rd_idx] : bp_isa_pkg::not_jump;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (update_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_en) begin
            kind_mem[wr_idx] <= wr_kind;
        end
    end

endmodule

// File: rtl/predictor.sv
module predictor #(
    parameter int k_width   = 6,
    parameter int h_width   = 8,
    parameter int stack_len = 8
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          stall,
    input  logic [bp_isa_pkg::addr_w-1:0] pc,
    input  logic                          update_en,
    input  bp_pipe_pkg::upd_t             upd,
    output bp_pipe_pkg::pred_t            pred
);
    logic [bp_isa_pkg::addr_w-1:0] pc_reg, npc;
    logic [k_width-1:0]            pc_idx, upd_idx;
    logic [15:0]                   pc_hash, upd_hash;
    bp_isa_pkg::branch_kind_e      kind;
    logic                          dir_taken, taken;
    logic                          pred_jump, upd_jump;
    logic [h_width-1:0]            gh, gh_commit, bh;
    logic                          choice_glb, choice_ras;
    logic [1:0]                    cnt_glb, cnt_ras;

    assign pc_hash   = bp_isa_pkg::fold_hash(pc, k_width);
    assign upd_hash  = bp_isa_pkg::fold_hash(upd.pc, k_width);
    assign upd_idx   = upd_hash[k_width-1:0];
    assign pred_jump = kind != bp_isa_pkg::not_jump;
    assign upd_jump  = upd.kind != bp_isa_pkg::not_jump;

    // fetch index, held on stall
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_reg <= '0;
            pc_idx <= '0;
        end else if (!stall) begin
            pc_reg <= pc;
            pc_idx <= pc_hash[k_width-1:0];
        end
    end

    always_comb begin
        case (kind)
            bp_isa_pkg::not_jump:    taken = 1'b0;
            bp_isa_pkg::direct_jump,
            bp_isa_pkg::other_jump:  taken = dir_taken;
            default:                 taken = 1'b1;  // unconditional kinds
        endcase
    end

    always_comb begin
        pred.npc            = npc;
        pred.kind           = kind;
        pred.taken          = taken;
        pred.bh             = 16'(bh);
        pred.choice.btb_ras = choice_ras;
        pred.choice.loc_glb = choice_glb;
        pred.choice_cnt_glb = cnt_glb;
        pred.choice_cnt_ras = cnt_ras;
    end

    kind_table #(.k_width(k_width)) u_kind_table (
        .clk(clk), .rstn(rstn), .rd_idx(pc_idx), .kind(kind),
        .update_en(update_en), .wr_idx(upd_idx), .wr_kind(upd.kind)
    );

    bht #(.k_width(k_width), .h_width(h_width)) u_bht (
        .clk(clk), .rstn(rstn), .rd_idx(pc_idx), .bh(bh),
        .update_en(update_en && upd_jump), .wr_idx(upd_idx),
        .wr_bh(upd.bh[h_width-1:0]), .taken(upd.taken)
    );

    ghr #(.h_width(h_width)) u_ghr (
        .clk(clk), .rstn(rstn), .stall(stall), .pred_jump(pred_jump),
        .pred_taken(taken), .upd_jump(upd_jump), .upd_taken(upd.taken),
        .mis_taken(upd.mis.taken), .update_en(update_en), .gh(gh), .gh_commit(gh_commit)
    );

    dir_predictor #(.k_width(k_width), .h_width(h_width)) u_dir_predictor (
        .clk(clk), .rstn(rstn), .pc_idx(pc_idx), .gh(gh), .bh(bh), .upd(upd),
        .update_en(update_en), .gh_commit(gh_commit), .taken(dir_taken),
        .choice_glb(choice_glb), .choice_cnt(cnt_glb)
    );

    target_predictor #(.k_width(k_width), .stack_len(stack_len)) u_target_predictor (
        .clk(clk), .rstn(rstn), .pc_idx(pc_idx), .pc_reg(pc_reg), .kind(kind),
        .taken(taken), .upd(upd), .update_en(update_en), .npc(npc),
        .choice_ras(choice_ras), .choice_cnt(cnt_ras)
    );

endmodule

// File: rtl/target_predictor.sv
module target_predictor #(
    parameter int k_width   = 6,
    parameter int stack_len = 8
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [k_width-1:0]            pc_idx,
    input  logic [bp_isa_pkg::addr_w-1:0] pc_reg,
    input  bp_isa_pkg::branch_kind_e      kind,
    input  logic                          taken,
    input  bp_pipe_pkg::upd_t             upd,
    input  logic                          update_en,
    output logic [bp_isa_pkg::addr_w-1:0] npc,
    output logic                          choice_ras,
    output logic [1:0]                    choice_cnt
);
    localparam int entries = 1 << k_width;
    localparam int ptr_w   = (stack_len > 1) ? $clog2(stack_len) : 1;

    logic [bp_isa_pkg::addr_w-1:0] btb_mem [entries];
    logic [entries-1:0]            btb_valid;
    logic [1:0]                    ras_cnt [entries];
    logic [bp_isa_pkg::addr_w-1:0] ras_mem [stack_len];
    logic [ptr_w-1:0]              ras_ptr;  // next free slot
    logic [ptr_w-1:0]              ras_top, ras_next;
    logic [ptr_w:0]                ras_depth;
    logic [15:0]                   upd_hash;
    logic [k_width-1:0]            upd_idx;
    logic [bp_isa_pkg::addr_w-1:0] seq_pc, btb_npc;
    logic                          push, pop;

    assign upd_hash = bp_isa_pkg::fold_hash(upd.pc, k_width);
    assign upd_idx  = upd_hash[k_width-1:0];
    assign seq_pc   = pc_reg + 1'b1;

    // circular stack pointer
    assign ras_top  = (ras_ptr == '0) ? ptr_w'(stack_len - 1) : ras_ptr - 1'b1;
    assign ras_next = (ras_ptr == ptr_w'(stack_len - 1)) ? '0 : ras_ptr + 1'b1;
    assign push     = update_en && upd.kind == bp_isa_pkg::call;
    assign pop      = update_en && upd.kind == bp_isa_pkg::ret && ras_depth != '0;

    assign btb_npc    = btb_valid[pc_idx] ? btb_mem[pc_idx] : seq_pc;
    assign choice_cnt = ras_cnt[pc_idx];
    // only a ret may use the stack, and only when it holds something
    assign choice_ras = (kind == bp_isa_pkg::ret) && choice_cnt[1] && (ras_depth != '0);

    always_comb begin
        if (!taken) begin
            npc = seq_pc;
        end else if (choice_ras) begin
            npc = ras_mem[ras_top];
        end else begin
            npc = btb_npc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            btb_valid <= '0;
            for (int i = 0; i < entries; i++) begin
                ras_cnt[i] <= 2'b10;  // lean to the stack
            end
        end else if (update_en) begin
            if (upd.taken && upd.kind != bp_isa_pkg::not_jump) begin
                btb_valid[upd_idx] <= 1'b1;
            end
            if (upd.kind == bp_isa_pkg::ret) begin
                ras_cnt[upd_idx] <= bp_isa_pkg::cnt_step(upd.choice_cnt_ras,
                                                         upd.choice_real.btb_ras);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_en && upd.taken && upd.kind != bp_isa_pkg::not_jump) begin
            btb_mem[upd_idx] <= upd.npc;
        end
        if (push) begin
            ras_mem[ras_ptr] <= upd.ret_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ras_ptr   <= '0;
            ras_depth <= '0;
        end else if (push) begin
            ras_ptr <= ras_next;
            if (ras_depth != (ptr_w + 1)'(stack_len)) begin
                ras_depth <= ras_depth + 1'b1;  // full stack overwrites oldest
            end
        end else if (pop) begin
            ras_ptr   <= ras_top;
            ras_depth <= ras_depth - 1'b1;
        end
    end

endmodule

// File: verif/predictor_checker.sv
module predictor_checker (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          check_en,
    input  logic [2:0]                    exp_kind,
    input  logic                          exp_taken,
    input  logic [bp_isa_pkg::addr_w-1:0] exp_npc,
    input  logic [191:0]                  test_name,
    input  bp_pipe_pkg::pred_t            pred,
    output int                            mismatches,
    output int                            checked
);
    timeunit 1ns;
    timeprecision 100ps;

    logic                          pend_en;
    logic [2:0]                    pend_kind;
    logic                          pend_taken;
    logic [bp_isa_pkg::addr_w-1:0] pend_npc;
    logic [191:0]                  pend_name;

    initial begin
        mismatches = 0;
        checked    = 0;
        pend_en    = 1'b0;
    end

    // pc sampled at this edge, its prediction shows up right after it
    always @(posedge clk) begin
        pend_en    <= rstn && check_en;
        pend_kind  <= exp_kind;
        pend_taken <= exp_taken;
        pend_npc   <= exp_npc;
        pend_name  <= test_name;
    end

    always @(negedge clk) begin
        if (pend_en) begin
            checked++;
            if (pred.kind !== pend_kind) begin
                $display("mismatch %0s kind: expected %0d, actual %0d",
                         pend_name, pend_kind, pred.kind);
                mismatches++;
            end
            if (pred.taken !== pend_taken) begin
                $display("mismatch %0s taken: expected %0b, actual %0b",
                         pend_name, pend_taken, pred.taken);
                mismatches++;
            end
            if (pred.npc !== pend_npc) begin
                $display("mismatch %0s npc: expected %0h, actual %0h",
                         pend_name, pend_npc, pred.npc);
                mismatches++;
            end
        end
    end

endmodule

// File: verif/predictor_properties.sv
module predictor_properties (
    input logic               clk,
    input logic               rstn,
    input logic               stall,
    input logic               update_en,
    input bp_pipe_pkg::pred_t pred
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // counters come up weakly not taken, stack chooser at 10
    reset_clears_pred: assert property (@(posedge clk)
        !rstn |=> (pred.kind == bp_isa_pkg::not_jump && !pred.taken && pred.bh == '0 &&
                   pred.choice == '0 && pred.choice_cnt_glb == 2'b01 &&
                   pred.choice_cnt_ras == 2'b10))
        else begin
            failures++;
            $error("prediction not cleared by reset");
        end

    // no table write either, so nothing may move
    stall_holds_pred: assert property (@(posedge clk) disable iff (!rstn)
        (stall && !update_en) |=> $stable(pred))
        else begin
            failures++;
            $error("prediction changed during a stalled cycle");
        end

endmodule

bind predictor predictor_properties u_properties (
    .clk(clk), .rstn(rstn), .stall(stall), .update_en(update_en), .pred(pred)
);

// File: verif/predictor_stim.txt
# name pc stall upd_en | upd: pc npc ret_pc kind taken bh choice cnt_glb cnt_ras mis | exp: kind taken npc
# all hex; choice is {btb_ras,loc_glb}, mis is {npc,kind,taken}
reset_seq       10 0 0 00 000 00 0 0 00 0 0 0 0 0 0 11
reset_seq       3f 0 0 00 000 00 0 0 00 0 0 0 0 0 0 40
jump_upd        20 0 1 04 200 00 2 1 00 0 1 2 0 0 0 21
jump_hit        04 0 0 00 000 00 0 0 00 0 0 0 0 2 1 200
dir_train       21 0 1 08 100 00 1 1 ff 0 1 2 0 0 0 22
dir_train       22 0 1 08 100 00 1 1 ff 0 1 2 0 0 0 23
dir_taken       08 0 0 00 000 00 0 0 00 0 0 0 0 1 1 100
dir_weaken      23 0 1 08 009 00 1 0 ff 0 1 2 0 0 0 24
dir_alias       24 0 1 09 00a 00 1 0 7f 0 1 2 0 0 0 25
dir_still_taken 09 0 0 00 000 00 0 0 00 0 0 0 0 1 1 0a
ret_install     25 0 1 18 1f0 00 4 1 00 2 1 2 0 0 0 26
call_push       26 0 1 0c 300 0d 3 1 00 0 1 2 0 0 0 27
ret_stack       18 0 0 00 000 00 0 0 00 0 0 0 0 4 1 0d
ret_pop         27 0 1 18 1f0 00 4 1 00 2 1 3 0 0 0 28
ret_btb         18 0 0 00 000 00 0 0 00 0 0 0 0 4 1 1f0
stall_hold      04 0 0 00 000 00 0 0 00 0 0 0 0 2 1 200
stall_hold      28 1 0 00 000 00 0 0 00 0 0 0 0 2 1 200
stall_hold      29 1 0 00 000 00 0 0 00 0 0 0 0 2 1 200
stall_release   2a 0 0 00 000 00 0 0 00 0 0 0 0 0 0 2b
ghist_restore   2b 0 1 1c 1d0 00 1 1 00 0 1 2 1 0 0 2c
ghist_train     2c 0 1 14 140 00 1 1 00 1 1 2 0 0 0 2d
ghist_hit       14 0 0 00 000 00 0 0 00 0 0 0 0 1 1 140

// File: verif/tb_predictor.sv
module tb_predictor;
    timeunit 1ns;
    timeprecision 100ps;

    // one stim line after parsing
    typedef struct packed {
        logic [bp_isa_pkg::addr_w-1:0] pc;
        logic                          stall;
        logic                          upd_en;
        bp_pipe_pkg::upd_t             upd;
        logic [2:0]                    exp_kind;
        logic                          exp_taken;
        logic [bp_isa_pkg::addr_w-1:0] exp_npc;
    } stim_row_t;

    logic                          clk;
    logic                          rstn;
    logic                          stall;
    logic                          update_en;
    logic [bp_isa_pkg::addr_w-1:0] pc;
    bp_pipe_pkg::upd_t             upd;
    bp_pipe_pkg::pred_t            pred;
    logic                          check_en;
    logic [2:0]                    exp_kind;
    logic                          exp_taken;
    logic [bp_isa_pkg::addr_w-1:0] exp_npc;
    logic [191:0]                  test_name;
    stim_row_t                     rows [$];
    logic [191:0]                  names [$];
    int                            parse_errors = 0;
    int                            mismatches;
    int                            checked;
    int                            cycles = 0;
    int                            cycle_limit = 50;

    predictor #(.k_width(6), .h_width(8), .stack_len(8)) UUT (
        .clk(clk), .rstn(rstn), .stall(stall), .pc(pc),
        .update_en(update_en), .upd(upd), .pred(pred)
    );

    predictor_checker u_checker (
        .clk(clk), .rstn(rstn), .check_en(check_en), .exp_kind(exp_kind),
        .exp_taken(exp_taken), .exp_npc(exp_npc), .test_name(test_name),
        .pred(pred), .mismatches(mismatches), .checked(checked)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic read_stim();
        int           fd;
        int           n;
        string        line;
        logic [191:0] name;
        logic [31:0]  f [16];
        stim_row_t    row;
        fd = $fopen("verif/predictor_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/predictor_stim.txt");
            parse_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;  // blank or comment
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15]);
            if (n != 17) begin
                $display("stim line could not be parsed: %0s", line);
                parse_errors++;
                continue;
            end
            row.pc                 = f[0][29:0];
            row.stall              = f[1][0];
            row.upd_en             = f[2][0];
            row.upd.pc             = f[3][29:0];
            row.upd.npc            = f[4][29:0];
            row.upd.ret_pc         = f[5][29:0];
            row.upd.kind           = bp_isa_pkg::branch_kind_e'(f[6][2:0]);
            row.upd.taken          = f[7][0];
            row.upd.bh             = f[8][15:0];
            row.upd.choice_real    = bp_pipe_pkg::choice_t'(f[9][1:0]);
            row.upd.choice_cnt_glb = f[10][1:0];
            row.upd.choice_cnt_ras = f[11][1:0];
            row.upd.mis            = bp_pipe_pkg::mis_t'(f[12][2:0]);
            row.exp_kind           = f[13][2:0];
            row.exp_taken          = f[14][0];
            row.exp_npc            = f[15][29:0];
            rows.push_back(row);
            names.push_back(name);
        end
        $fclose(fd);
    endtask

    task automatic drive_row(input stim_row_t row, input logic [191:0] name);
        pc        = row.pc;
        stall     = row.stall;
        update_en = row.upd_en;
        upd       = row.upd;
        if (row.upd.kind != bp_isa_pkg::call) begin
            upd.ret_pc = bp_isa_pkg::addr_w'($urandom);  // unused outside calls
        end
        check_en  = 1'b1;
        exp_kind  = row.exp_kind;
        exp_taken = row.exp_taken;
        exp_npc   = row.exp_npc;
        test_name = name;
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d unparsed, %0d assertion failures, %0d checked",
                 mismatches, parse_errors, UUT.u_properties.failures, checked);
    endtask

    initial begin
        void'($urandom(3));
        rstn      = 1'b0;
        stall     = 1'b0;
        update_en = 1'b0;
        pc        = '0;
        upd       = '0;
        check_en  = 1'b0;
        exp_kind  = '0;
        exp_taken = 1'b0;
        exp_npc   = '0;
        test_name = '0;
        read_stim();
        cycle_limit = 2 * rows.size() + 50;
        repeat (16) @(posedge clk);
        #1 rstn = 1'b1;
        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            drive_row(rows[i], names[i]);
        end
        @(posedge clk);
        #1;
        check_en  = 1'b0;
        update_en = 1'b0;
        stall     = 1'b0;
        repeat (2) @(posedge clk);  // let the last compare land
        print_counts();
        if (mismatches == 0 && parse_errors == 0 && checked > 0 &&
            UUT.u_properties.failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            print_counts();
            $display("Test FAILED");
            $finish;
        end
    end

endmodule
